// File: logic/lb_pkg.sv
`default_nettype none

package lb_pkg;

  // Local bus geometry
  localparam int LB_ADDR_W = 8;
  localparam int LB_DATA_W = 32;

  // One register request as seen by the arbiter
  typedef struct packed {
    logic                 wr;
    logic [LB_ADDR_W-1:0] addr;
    logic [LB_DATA_W-1:0] data;
  } lb_req_t;

  // Register map of the I2C master

  // Slave address sits in bits 7:1
  localparam logic [LB_ADDR_W-1:0] I2C_ADDR_REG    = 8'h00;

  // SCL bit period minus one, in clock cycles
  localparam logic [LB_ADDR_W-1:0] I2C_CLK_DIV_REG = 8'h01;

  // Start, stop, init, read and byte count
  localparam logic [LB_ADDR_W-1:0] I2C_CONFIG_REG  = 8'h02;

  // Bit 1 nack, bit 0 busy
  localparam logic [LB_ADDR_W-1:0] I2C_STATUS_REG  = 8'h03;

  // Current FSM state code
  localparam logic [LB_ADDR_W-1:0] I2C_FSM_REG     = 8'h04;

  // First byte of the data cache
  localparam logic [LB_ADDR_W-1:0] I2C_DATA_BASE   = 8'h10;

endpackage

`default_nettype wire

// File: logic/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

  // Transaction FSM states
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    START = 3'd1,
    ADDR  = 3'd2,
    ACK   = 3'd3,
    DATA  = 3'd4,
    STOP  = 3'd5
  } i2c_state_e;

  // SDA levels during the acknowledge bit
  localparam logic ACK_VAL  = 1'b0;
  localparam logic NACK_VAL = 1'b1;

  // Bit positions in the configuration word
  localparam int unsigned CFG_START_BIT  = 0;
  localparam int unsigned CFG_STOP_BIT   = 1;
  localparam int unsigned CFG_INIT_BIT   = 2;
  localparam int unsigned CFG_RD_BIT     = 3;
  localparam int unsigned CFG_NBYTES_LSB = 8;

endpackage

`default_nettype wire

// File: logic/lb_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module lb_arbiter #(
  parameter type payload_t = logic
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [1:0]                   valid_i,
  input  payload_t                     req0_i,
  input  payload_t                     req1_i,
  output logic [1:0]                   ready_o,
  output payload_t                     gnt_req_o,
  output logic                         gnt_valid_o,
  input  logic                         rsp_done_i,
  input  logic [lb_pkg::LB_DATA_W-1:0] rsp_data_i,
  output logic [1:0]                   rsp_valid_o,
  output logic [lb_pkg::LB_DATA_W-1:0] rsp_data_o
);

  logic prio_q;
  logic pending_q;
  logic owner_q;
  logic sel;
  logic accept;

  // Priority host wins if it is valid, otherwise the other one
  assign sel = valid_i[prio_q] ? prio_q : ~prio_q;

  // An idle host may see ready, a valid host only when selected
  assign ready_o[0] = ~pending_q & (~valid_i[0] | (sel == 1'b0));
  assign ready_o[1] = ~pending_q & (~valid_i[1] | (sel == 1'b1));

  assign accept = |(valid_i & ready_o);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prio_q      <= 1'b0;
      pending_q   <= 1'b0;
      owner_q     <= 1'b0;
      gnt_valid_o <= 1'b0;
    end
    else
    begin
      gnt_valid_o <= accept;
      if (accept)
      begin
        pending_q <= 1'b1;
        owner_q   <= sel;
        // Other host goes first next time
        prio_q    <= ~sel;
      end
      else if (rsp_done_i)
      begin
        pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      gnt_req_o <= sel ? req1_i : req0_i;
    end
  end

  // Response goes back to whoever owns the pending request
  assign rsp_valid_o = {2{rsp_done_i & pending_q}} & {owner_q, ~owner_q};
  assign rsp_data_o  = rsp_done_i ? rsp_data_i : '0;

endmodule

`default_nettype wire

// File: logic/i2c_tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_tick_gen #(
  parameter int CLK_DIV_W = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 run_i,
  input  logic [CLK_DIV_W-1:0] div_i,
  output logic                 tick_o,
  output logic                 half_o,
  output logic                 quarter_o
);

  logic [CLK_DIV_W-1:0] cnt_q;
  logic [CLK_DIV_W-1:0] div_half;
  logic [CLK_DIV_W-1:0] div_qtr;
  logic [CLK_DIV_W-1:0] div_3qtr;
  logic                 at_end;

  // Phase points inside one bit period
  assign div_half = div_i >> 1;
  assign div_qtr  = div_i >> 2;
  assign div_3qtr = div_half + div_qtr;

  assign at_end = (cnt_q == div_i);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q <= '0;
    end
    else if (!run_i || at_end)
    begin
      cnt_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Wrap also counts as a half point, half points as quarter points
  assign tick_o    = run_i & at_end;
  assign half_o    = run_i & (at_end | (cnt_q == div_half));
  assign quarter_o = half_o | (run_i & ((cnt_q == div_qtr) | (cnt_q == div_3qtr)));

endmodule

`default_nettype wire

// File: logic/i2c_master.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_master #(
  parameter int CLK_DIV_W = 8,
  parameter int MAX_BYTES = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         lb_wr_en_i,
  input  logic                         lb_rd_en_i,
  input  logic [lb_pkg::LB_ADDR_W-1:0] lb_addr_i,
  input  logic [lb_pkg::LB_DATA_W-1:0] lb_wr_data_i,
  output logic                         lb_wr_valid_o,
  output logic                         lb_rd_valid_o,
  output logic [lb_pkg::LB_DATA_W-1:0] lb_rd_data_o,
  output logic                         scl_o,
  output logic                         sda_oe_o,
  input  logic                         sda_i
);

  localparam int NB_W  = $clog2(MAX_BYTES) + 1;
  localparam int IDX_W = (MAX_BYTES > 1) ? $clog2(MAX_BYTES) : 1;
  localparam logic [NB_W-1:0] NB_MAX = NB_W'(MAX_BYTES);

  logic [6:0]                    cfg_addr_q;
  logic [CLK_DIV_W-1:0]          cfg_div_q;
  logic [NB_W-1:0]               cfg_nbytes_q;
  logic                          cfg_start_q;
  logic                          cfg_stop_q;
  logic                          cfg_rd_q;
  logic                          cfg_init_q;
  logic [7:0]                    cache [MAX_BYTES];
  logic [lb_pkg::LB_ADDR_W-1:0]  cache_off;
  logic                          in_cache;
  logic [NB_W-1:0]               nbytes_wr;
  logic [lb_pkg::LB_DATA_W-1:0]  rd_mux;

  i2c_pkg::i2c_state_e           state_q;
  logic [7:0]                    sh_q;
  logic [2:0]                    bit_cnt_q;
  logic [NB_W-1:0]               byte_idx_q;
  logic                          data_seen_q;
  logic                          nack_q;
  logic                          sda_meta_q;
  logic                          sda_s_q;
  logic                          busy;
  logic                          tick;
  logic                          half;
  logic                          quarter;
  logic                          tx_bit_en;
  logic                          master_acks;
  logic                          mack_lvl;
  logic                          last_byte;
  logic                          nack_smp;
  logic                          rx_smp;

  assign cache_off = lb_addr_i - lb_pkg::I2C_DATA_BASE;
  assign in_cache  = (lb_addr_i >= lb_pkg::I2C_DATA_BASE) && (cache_off < MAX_BYTES);
  assign nbytes_wr = lb_wr_data_i[i2c_pkg::CFG_NBYTES_LSB +: NB_W];
  assign busy      = (state_q != i2c_pkg::IDLE);

  // Register writes, one-cycle response
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cfg_addr_q    <= '0;
      cfg_div_q     <= '0;
      cfg_nbytes_q  <= '0;
      cfg_start_q   <= 1'b0;
      cfg_stop_q    <= 1'b0;
      cfg_rd_q      <= 1'b0;
      cfg_init_q    <= 1'b0;
      lb_wr_valid_o <= 1'b0;
      lb_rd_valid_o <= 1'b0;
      lb_rd_data_o  <= '0;
    end
    else
    begin
      lb_wr_valid_o <= lb_wr_en_i;
      lb_rd_valid_o <= lb_rd_en_i;
      lb_rd_data_o  <= lb_rd_en_i ? rd_mux : '0;
      // Init only lives for one cycle
      cfg_init_q    <= 1'b0;
      if (lb_wr_en_i)
      begin
        case (lb_addr_i)
          lb_pkg::I2C_ADDR_REG:    cfg_addr_q <= lb_wr_data_i[7:1];
          lb_pkg::I2C_CLK_DIV_REG: cfg_div_q  <= lb_wr_data_i[CLK_DIV_W-1:0];
          lb_pkg::I2C_CONFIG_REG:
          begin
            cfg_start_q  <= lb_wr_data_i[i2c_pkg::CFG_START_BIT];
            cfg_stop_q   <= lb_wr_data_i[i2c_pkg::CFG_STOP_BIT];
            cfg_init_q   <= lb_wr_data_i[i2c_pkg::CFG_INIT_BIT];
            cfg_rd_q     <= lb_wr_data_i[i2c_pkg::CFG_RD_BIT];
            cfg_nbytes_q <= (nbytes_wr > NB_MAX) ? NB_MAX : nbytes_wr;
          end
          default: ;
        endcase
      end
    end
  end

  always_comb
  begin
    rd_mux = '0;
    case (lb_addr_i)
      lb_pkg::I2C_ADDR_REG:    rd_mux[7:0] = {cfg_addr_q, 1'b0};
      lb_pkg::I2C_CLK_DIV_REG: rd_mux[CLK_DIV_W-1:0] = cfg_div_q;
      lb_pkg::I2C_CONFIG_REG:
      begin
        rd_mux[i2c_pkg::CFG_START_BIT]           = cfg_start_q;
        rd_mux[i2c_pkg::CFG_STOP_BIT]            = cfg_stop_q;
        rd_mux[i2c_pkg::CFG_INIT_BIT]            = cfg_init_q;
        rd_mux[i2c_pkg::CFG_RD_BIT]              = cfg_rd_q;
        rd_mux[i2c_pkg::CFG_NBYTES_LSB +: NB_W]  = cfg_nbytes_q;
      end
      lb_pkg::I2C_STATUS_REG:  rd_mux[1:0] = {nack_q, busy};
      lb_pkg::I2C_FSM_REG:     rd_mux[2:0] = state_q;
      default:
      begin
        if (in_cache)
        begin
          rd_mux[7:0] = cache[cache_off[IDX_W-1:0]];
        end
      end
    endcase
  end

  // Host writes win over bytes shifted in from the bus
  always_ff @(posedge clk)
  begin
    if (lb_wr_en_i && in_cache)
    begin
      cache[cache_off[IDX_W-1:0]] <= lb_wr_data_i[7:0];
    end
    else if (rx_smp)
    begin
      cache[byte_idx_q[IDX_W-1:0]] <= {cache[byte_idx_q[IDX_W-1:0]][6:0], sda_s_q};
    end
  end

  // Two-flop synchronizer, idles at the pulled-up level
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sda_meta_q <= 1'b1;
      sda_s_q    <= 1'b1;
    end
    else
    begin
      sda_meta_q <= sda_i;
      sda_s_q    <= sda_meta_q;
    end
  end

  // Divider must be 4 or more so the quarter points stay apart
  i2c_tick_gen #(
    .CLK_DIV_W (CLK_DIV_W)
  ) i_tick_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .run_i     (busy),
    .div_i     (cfg_div_q),
    .tick_o    (tick),
    .half_o    (half),
    .quarter_o (quarter)
  );

  assign tx_bit_en   = (state_q == i2c_pkg::ADDR) | ~cfg_rd_q;
  assign master_acks = cfg_rd_q & data_seen_q;
  assign mack_lvl    = (byte_idx_q + 1'b1 < cfg_nbytes_q) ? i2c_pkg::ACK_VAL : i2c_pkg::NACK_VAL;
  assign last_byte   = (byte_idx_q == cfg_nbytes_q);
  // Sample at mid SCL high
  assign nack_smp    = (state_q == i2c_pkg::ACK) & ~master_acks & half & scl_o
                       & (sda_s_q == i2c_pkg::NACK_VAL);
  assign rx_smp      = (state_q == i2c_pkg::DATA) & cfg_rd_q & half & scl_o;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= i2c_pkg::IDLE;
      sh_q        <= '0;
      bit_cnt_q   <= '0;
      byte_idx_q  <= '0;
      data_seen_q <= 1'b0;
      nack_q      <= 1'b0;
      scl_o       <= 1'b0;
      sda_oe_o    <= 1'b0;
    end
    else
    begin
      if (cfg_init_q)
      begin
        nack_q <= 1'b0;
      end
      else if (nack_smp)
      begin
        nack_q <= 1'b1;
      end

      case (state_q)
        i2c_pkg::IDLE:
        begin
          scl_o       <= 1'b0;
          sda_oe_o    <= 1'b0;
          bit_cnt_q   <= '0;
          byte_idx_q  <= '0;
          data_seen_q <= 1'b0;
          if (cfg_init_q)
          begin
            sh_q <= {cfg_addr_q, cfg_rd_q};
            if (cfg_start_q)
            begin
              // Both lines high ahead of the START
              state_q <= i2c_pkg::START;
              scl_o   <= 1'b1;
            end
            else
            begin
              state_q  <= i2c_pkg::ADDR;
              sda_oe_o <= ~cfg_addr_q[6];
            end
          end
        end

        i2c_pkg::START:
        begin
          if (tick)
          begin
            state_q  <= i2c_pkg::ADDR;
            sda_oe_o <= ~sh_q[7];
          end
          else if (half)
          begin
            sda_oe_o <= 1'b1;
          end
          else if (quarter && sda_oe_o)
          begin
            scl_o <= 1'b0;
          end
        end

        i2c_pkg::ADDR, i2c_pkg::DATA:
        begin
          // SCL rises at the first quarter and falls at the third
          if (quarter && !half)
          begin
            scl_o <= ~scl_o;
          end
          if (tick)
          begin
            if (bit_cnt_q == 3'd7)
            begin
              bit_cnt_q <= '0;
              state_q   <= i2c_pkg::ACK;
              // Master drives ACK only after a read byte
              sda_oe_o  <= (state_q == i2c_pkg::DATA) & cfg_rd_q & ~mack_lvl;
              if (state_q == i2c_pkg::DATA)
              begin
                byte_idx_q <= byte_idx_q + 1'b1;
              end
            end
            else
            begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              sh_q      <= {sh_q[6:0], 1'b0};
              sda_oe_o  <= tx_bit_en & ~sh_q[6];
            end
          end
        end

        i2c_pkg::ACK:
        begin
          if (quarter && !half)
          begin
            scl_o <= ~scl_o;
          end
          if (tick)
          begin
            if (nack_q || last_byte)
            begin
              state_q  <= cfg_stop_q ? i2c_pkg::STOP : i2c_pkg::IDLE;
              // SDA low under SCL low before the STOP
              sda_oe_o <= cfg_stop_q;
            end
            else
            begin
              state_q     <= i2c_pkg::DATA;
              data_seen_q <= 1'b1;
              sh_q        <= cache[byte_idx_q[IDX_W-1:0]];
              sda_oe_o    <= ~cfg_rd_q & ~cache[byte_idx_q[IDX_W-1:0]][7];
            end
          end
        end

        i2c_pkg::STOP:
        begin
          if (tick)
          begin
            state_q <= i2c_pkg::IDLE;
          end
          else if (half && scl_o)
          begin
            sda_oe_o <= 1'b0;
          end
          else if (quarter && !half)
          begin
            scl_o <= 1'b1;
          end
        end

        default: state_q <= i2c_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/i2c_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_ctrl_top #(
  parameter int CLK_DIV_W = 8,
  parameter int MAX_BYTES = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         h0_valid_i,
  input  lb_pkg::lb_req_t              h0_req_i,
  output logic                         h0_ready_o,
  output logic                         h0_rsp_valid_o,
  output logic [lb_pkg::LB_DATA_W-1:0] h0_rsp_data_o,
  input  logic                         h1_valid_i,
  input  lb_pkg::lb_req_t              h1_req_i,
  output logic                         h1_ready_o,
  output logic                         h1_rsp_valid_o,
  output logic [lb_pkg::LB_DATA_W-1:0] h1_rsp_data_o,
  output logic                         scl_o,
  inout  wire                          sda
);

  lb_pkg::lb_req_t              gnt_req;
  logic                         gnt_valid;
  logic                         lb_wr_en;
  logic                         lb_rd_en;
  logic                         lb_wr_valid;
  logic                         lb_rd_valid;
  logic [lb_pkg::LB_DATA_W-1:0] lb_rd_data;
  logic [lb_pkg::LB_DATA_W-1:0] rsp_data;
  logic                         sda_oe;

  lb_arbiter #(
    .payload_t (lb_pkg::lb_req_t)
  ) i_lb_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     ({h1_valid_i, h0_valid_i}),
    .req0_i      (h0_req_i),
    .req1_i      (h1_req_i),
    .ready_o     ({h1_ready_o, h0_ready_o}),
    .gnt_req_o   (gnt_req),
    .gnt_valid_o (gnt_valid),
    .rsp_done_i  (lb_wr_valid | lb_rd_valid),
    .rsp_data_i  (lb_rd_data),
    .rsp_valid_o ({h1_rsp_valid_o, h0_rsp_valid_o}),
    .rsp_data_o  (rsp_data)
  );

  // Grant strobe split by direction
  assign lb_wr_en = gnt_valid & gnt_req.wr;
  assign lb_rd_en = gnt_valid & ~gnt_req.wr;

  assign h0_rsp_data_o = rsp_data;
  assign h1_rsp_data_o = rsp_data;

  i2c_master #(
    .CLK_DIV_W (CLK_DIV_W),
    .MAX_BYTES (MAX_BYTES)
  ) i_i2c_master (
    .clk           (clk),
    .rst_n         (rst_n),
    .lb_wr_en_i    (lb_wr_en),
    .lb_rd_en_i    (lb_rd_en),
    .lb_addr_i     (gnt_req.addr),
    .lb_wr_data_i  (gnt_req.data),
    .lb_wr_valid_o (lb_wr_valid),
    .lb_rd_valid_o (lb_rd_valid),
    .lb_rd_data_o  (lb_rd_data),
    .scl_o         (scl_o),
    .sda_oe_o      (sda_oe),
    .sda_i         (sda)
  );

  // Open drain, pulled up off chip
  assign sda = sda_oe ? 1'b0 : 1'bz;

endmodule

`default_nettype wire

// File: tests/i2c_ctrl_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_ctrl_assertions (
  input wire       clk,
  input wire       rst_n,
  input wire [1:0] valid_i,
  input wire [1:0] ready_i,
  input wire [1:0] rsp_valid_i,
  input wire       init_i,
  input wire       scl_i
);

  logic       seen_init;
  logic       inflight_q;
  logic [1:0] hs;

  assign hs = valid_i & ready_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      seen_init <= 1'b0;
    end
    else if (init_i)
    begin
      seen_init <= 1'b1;
    end
  end

  // Request outstanding from its handshake until its response
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      inflight_q <= 1'b0;
    end
    else if (|hs)
    begin
      inflight_q <= 1'b1;
    end
    else if (|rsp_valid_i)
    begin
      inflight_q <= 1'b0;
    end
  end

  a_onehot_grant: assert property (@(posedge clk) disable iff (!rst_n)
                                   (|valid_i) && !inflight_q |-> $onehot(hs))
    else $error("bus free with a host valid but not exactly one host granted");

  a_rsp_h0: assert property (@(posedge clk) disable iff (!rst_n) hs[0] |-> ##2 rsp_valid_i[0])
    else $error("host 0 response not 2 cycles after handshake");

  a_rsp_h1: assert property (@(posedge clk) disable iff (!rst_n) hs[1] |-> ##2 rsp_valid_i[1])
    else $error("host 1 response not 2 cycles after handshake");

  a_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
                                inflight_q |-> ready_i == 2'b00)
    else $error("ready high with a request pending");

  a_scl_idle: assert property (@(posedge clk) disable iff (!rst_n) !seen_init |-> !scl_i)
    else $error("scl toggled before the first init");

endmodule

bind i2c_ctrl_top i2c_ctrl_assertions i_i2c_ctrl_assertions (
  .clk         (clk),
  .rst_n       (rst_n),
  .valid_i     ({h1_valid_i, h0_valid_i}),
  .ready_i     ({h1_ready_o, h0_ready_o}),
  .rsp_valid_i ({h1_rsp_valid_o, h0_rsp_valid_o}),
  .init_i      (i_i2c_master.cfg_init_q),
  .scl_i       (scl_o)
);

`default_nettype wire

// File: tests/tb_i2c_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_i2c_ctrl;

  localparam int CLK_DIV_W = 8;
  localparam int MAX_BYTES = 4;
  localparam int N_TXN     = 8;
  localparam int DIV_MAX   = 15;
  localparam int LIMIT     = N_TXN * (MAX_BYTES + 2) * 9 * (DIV_MAX + 1) + 4000;
  localparam logic [6:0] SLV_ADDR = 7'h2a;
  localparam int START_EV  = 256;
  localparam int STOP_EV   = 257;

  logic            clk = 1'b0;
  logic            rst_n = 1'b0;
  logic [1:0]      h_valid = 2'b00;
  lb_pkg::lb_req_t h_req [2];
  wire  [1:0]      h_ready;
  wire  [1:0]      h_rsp_valid;
  wire  [31:0]     rsp_data0;
  wire  [31:0]     rsp_data1;
  wire             scl;
  wire             sda;

  integer seed = 69017;
  int     cycles = 0;
  int     err_cnt = 0;
  int     gnt_log [$];

  // Reference model of the register block
  logic [6:0] m_addr = '0;
  logic [7:0] m_div = '0;
  logic       m_start = 1'b0;
  logic       m_stop = 1'b0;
  logic       m_rd = 1'b0;
  logic [2:0] m_nb = '0;
  logic [7:0] m_cache [MAX_BYTES];

  // Slave model state
  logic       slv_oe = 1'b0;
  int         bitn = 0;
  int         byte_no = 0;
  logic [7:0] shreg = '0;
  logic [7:0] tx_byte = '0;
  logic       is_rd = 1'b0;
  logic       matched = 1'b0;
  logic       mack = 1'b1;
  logic       sending = 1'b0;
  int         bus_log [$];
  logic [7:0] rd_data [$];
  logic [7:0] sent [$];

  pullup (sda);
  assign sda = slv_oe ? 1'b0 : 1'bz;

  i2c_ctrl_top #(
    .CLK_DIV_W (CLK_DIV_W),
    .MAX_BYTES (MAX_BYTES)
  ) i_i2c_ctrl_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .h0_valid_i     (h_valid[0]),
    .h0_req_i       (h_req[0]),
    .h0_ready_o     (h_ready[0]),
    .h0_rsp_valid_o (h_rsp_valid[0]),
    .h0_rsp_data_o  (rsp_data0),
    .h1_valid_i     (h_valid[1]),
    .h1_req_i       (h_req[1]),
    .h1_ready_o     (h_ready[1]),
    .h1_rsp_valid_o (h_rsp_valid[1]),
    .h1_rsp_data_o  (rsp_data1),
    .scl_o          (scl),
    .sda            (sda)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("Run took too long, a transaction or handshake never completed");
      $display(">>> FAIL");
      $fatal(1);
    end
  end

  // START and STOP only count while SCL is high
  always @(negedge sda)
  begin
    if (scl === 1'b1)
    begin
      bus_log.push_back(START_EV);
      bitn = 0;
      byte_no = 0;
      matched = 1'b0;
    end
  end

  always @(posedge sda)
  begin
    if (scl === 1'b1)
    begin
      bus_log.push_back(STOP_EV);
      bitn = 0;
      byte_no = 0;
      matched = 1'b0;
    end
  end

  always @(posedge scl)
  begin
    if (bitn < 8)
    begin
      shreg = {shreg[6:0], sda};
      bitn = bitn + 1;
      if (bitn == 8 && byte_no == 0)
      begin
        is_rd = shreg[0];
        matched = (shreg[7:1] == SLV_ADDR);
        bus_log.push_back(int'(shreg));
      end
      else if (bitn == 8 && !is_rd)
      begin
        bus_log.push_back(int'(shreg));
      end
    end
    else
    begin
      // Ninth clock carries the acknowledge
      mack = sda;
      bitn = 0;
      byte_no = byte_no + 1;
    end
  end

  always @(negedge scl)
  begin
    slv_oe = 1'b0;
    if (matched && bitn == 8)
    begin
      slv_oe = (byte_no == 0) || !is_rd;
    end
    else if (matched && is_rd && byte_no > 0)
    begin
      if (bitn == 0)
      begin
        sending = (byte_no == 1 || mack == i2c_pkg::ACK_VAL) && rd_data.size() > 0;
        if (sending)
        begin
          tx_byte = rd_data.pop_front();
          sent.push_back(tx_byte);
        end
      end
      if (sending)
      begin
        slv_oe = ~tx_byte[7 - bitn];
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  task automatic slave_clear();
    bitn = 0;
    byte_no = 0;
    matched = 1'b0;
    is_rd = 1'b0;
    sending = 1'b0;
    mack = 1'b1;
    bus_log.delete();
    sent.delete();
  endtask

  task automatic host_request(input int h, input logic wr, input logic [7:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata);
    int n;
    h_req[h]   <= {wr, addr, data};
    h_valid[h] <= 1'b1;
    @(posedge clk);
    while (!h_ready[h])
    begin
      @(posedge clk);
    end
    gnt_log.push_back(h);
    h_valid[h] <= 1'b0;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
    end while (!h_rsp_valid[h] && n < 8);
    check_value("rsp_latency", n, 2);
    check_value("h_rsp_valid_other", h_rsp_valid[1 - h], 1'b0);
    rdata = h ? rsp_data1 : rsp_data0;
    if (wr)
    begin
      check_value("rsp_data_wr", rdata, 32'h0);
    end
  endtask

  task automatic write_reg(input int h, input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    host_request(h, 1'b1, addr, data, unused);
  endtask

  task automatic expect_reg(input int h, input logic [7:0] addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] rd;
    host_request(h, 1'b0, addr, 32'h0, rd);
    check_value(name, rd, exp);
  endtask

  // Readback values built from the register rules
  function automatic logic [31:0] cfg_word();
    return {21'h0, m_nb, 4'h0, m_rd, 1'b0, m_stop, m_start};
  endfunction

  task automatic expect_all_regs(input int h);
    expect_reg(h, lb_pkg::I2C_ADDR_REG, {24'h0, m_addr, 1'b0}, "addr_reg");
    expect_reg(h, lb_pkg::I2C_CLK_DIV_REG, {24'h0, m_div}, "clk_div_reg");
    expect_reg(h, lb_pkg::I2C_CONFIG_REG, cfg_word(), "config_reg");
    expect_reg(h, lb_pkg::I2C_STATUS_REG, 32'h0, "status_reg");
    expect_reg(h, lb_pkg::I2C_FSM_REG, i2c_pkg::IDLE, "fsm_reg");
    for (int i = 0; i < MAX_BYTES; i++)
    begin
      expect_reg(h, lb_pkg::I2C_DATA_BASE + i, {24'h0, m_cache[i]}, "data_reg");
    end
  endtask

  task automatic run_transaction(input logic start, input logic stop, input logic rd,
                                 input logic [6:0] addr, input int nb);
    logic [31:0] st;
    m_div = 8'(4 + {$random(seed)} % (DIV_MAX - 3));
    write_reg(0, lb_pkg::I2C_CLK_DIV_REG, {24'h0, m_div});
    m_addr = addr;
    write_reg(1, lb_pkg::I2C_ADDR_REG, {24'h0, addr, 1'b0});
    slave_clear();
    m_start = start;
    m_stop  = stop;
    m_rd    = rd;
    m_nb    = 3'(nb);
    write_reg(0, lb_pkg::I2C_CONFIG_REG, cfg_word() | 32'h4);
    do
    begin
      host_request(1, 1'b0, lb_pkg::I2C_STATUS_REG, 32'h0, st);
    end while (st[0]);
  endtask

  task automatic compare_bus(input int exp [$]);
    check_value("bus_log_len", bus_log.size(), exp.size());
    foreach (exp[i])
    begin
      check_value("bus_log", bus_log[i], exp[i]);
    end
  endtask

  task automatic arb_sequence(input int h, input logic [7:0] v0, input logic [7:0] v1);
    write_reg(h, lb_pkg::I2C_DATA_BASE + 2 * h, {24'h0, v0});
    write_reg(h, lb_pkg::I2C_DATA_BASE + 2 * h + 1, {24'h0, v1});
    expect_reg(h, lb_pkg::I2C_DATA_BASE + 2 * h, {24'h0, v0}, "arb_data0");
    expect_reg(h, lb_pkg::I2C_DATA_BASE + 2 * h + 1, {24'h0, v1}, "arb_data1");
  endtask

  task automatic write_test(input logic [6:0] addr, input int nb, input logic start,
                            input logic stop, input logic [31:0] exp_status);
    int exp [$];
    for (int i = 0; i < nb; i++)
    begin
      m_cache[i] = 8'($random(seed));
      write_reg(i % 2, lb_pkg::I2C_DATA_BASE + i, {24'h0, m_cache[i]});
    end
    run_transaction(start, stop, 1'b0, addr, nb);
    if (start)
    begin
      exp.push_back(START_EV);
    end
    exp.push_back({addr, 1'b0});
    for (int i = 0; i < nb && addr == SLV_ADDR; i++)
    begin
      exp.push_back(m_cache[i]);
    end
    if (stop)
    begin
      exp.push_back(STOP_EV);
    end
    compare_bus(exp);
    expect_reg(0, lb_pkg::I2C_STATUS_REG, exp_status, "status_reg");
  endtask

  task automatic read_test(input int nb);
    int exp [$];
    rd_data.delete();
    for (int i = 0; i < nb; i++)
    begin
      rd_data.push_back(8'($random(seed)));
    end
    run_transaction(1'b1, 1'b1, 1'b1, SLV_ADDR, nb);
    exp = '{START_EV, {SLV_ADDR, 1'b1}, STOP_EV};
    compare_bus(exp);
    check_value("sent_count", sent.size(), nb);
    for (int i = 0; i < nb; i++)
    begin
      m_cache[i] = sent[i];
      expect_reg(1, lb_pkg::I2C_DATA_BASE + i, {24'h0, sent[i]}, "rd_cache");
    end
    expect_reg(0, lb_pkg::I2C_STATUS_REG, 32'h0, "status_reg");
  endtask

  initial
  begin
    logic [31:0] val;
    int          h;
    int          sel;
    int          idx;
    logic [7:0]  av [4];

    h_req[0] = '0;
    h_req[1] = '0;
    for (int i = 0; i < MAX_BYTES; i++)
    begin
      m_cache[i] = '0;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("h_ready", h_ready, 2'b11);
    check_value("h_rsp_valid", h_rsp_valid, 2'b00);
    check_value("scl", scl, 1'b0);
    check_value("sda", sda, 1'b1);

    // Cache is not reset, so fill it first
    for (int i = 0; i < MAX_BYTES; i++)
    begin
      write_reg(i % 2, lb_pkg::I2C_DATA_BASE + i, 32'h0);
    end

    // Random register traffic from both hosts
    for (int i = 0; i < 40; i++)
    begin
      h   = {$random(seed)} % 2;
      sel = {$random(seed)} % 4;
      val = $random(seed);
      case (sel)
        0:
        begin
          m_addr = val[7:1];
          write_reg(h, lb_pkg::I2C_ADDR_REG, val);
          expect_reg(1 - h, lb_pkg::I2C_ADDR_REG, {24'h0, m_addr, 1'b0}, "addr_reg");
        end
        1:
        begin
          m_div = val[7:0];
          write_reg(h, lb_pkg::I2C_CLK_DIV_REG, val);
          expect_reg(h, lb_pkg::I2C_CLK_DIV_REG, {24'h0, m_div}, "clk_div_reg");
        end
        2:
        begin
          val[i2c_pkg::CFG_INIT_BIT] = 1'b0;
          m_start = val[0];
          m_stop  = val[1];
          m_rd    = val[3];
          m_nb    = (val[10:8] > MAX_BYTES) ? 3'(MAX_BYTES) : val[10:8];
          write_reg(h, lb_pkg::I2C_CONFIG_REG, val);
          expect_reg(1 - h, lb_pkg::I2C_CONFIG_REG, cfg_word(), "config_reg");
        end
        default:
        begin
          idx = {$random(seed)} % MAX_BYTES;
          m_cache[idx] = val[7:0];
          write_reg(h, lb_pkg::I2C_DATA_BASE + idx, val);
          expect_reg(h, lb_pkg::I2C_DATA_BASE + idx, {24'h0, m_cache[idx]}, "data_reg");
        end
      endcase
    end
    expect_all_regs(0);
    expect_all_regs(1);

    // Both hosts busy at once, grants must alternate
    for (int i = 0; i < 4; i++)
    begin
      av[i] = 8'($random(seed));
    end
    gnt_log.delete();
    fork
      arb_sequence(0, av[0], av[1]);
      arb_sequence(1, av[2], av[3]);
    join
    check_value("gnt_count", gnt_log.size(), 8);
    foreach (gnt_log[i])
    begin
      check_value("gnt_host", gnt_log[i], i % 2);
    end
    for (int i = 0; i < 4; i++)
    begin
      m_cache[i] = av[i];
    end

    for (int i = 0; i < 3; i++)
    begin
      write_test(SLV_ADDR, 1 + {$random(seed)} % MAX_BYTES, 1'b1, 1'b1, 32'h0);
    end
    read_test(1 + {$random(seed)} % MAX_BYTES);
    read_test(MAX_BYTES);

    // Wrong address gets a NACK, next init clears it
    write_test(SLV_ADDR ^ 7'h01, 2, 1'b1, 1'b1, 32'h2);
    write_test(SLV_ADDR, 1, 1'b1, 1'b1, 32'h0);

    // No START and no STOP on the bus
    write_test(SLV_ADDR, 1, 1'b0, 1'b0, 32'h0);
    expect_all_regs(1);

    if (err_cnt == 0)
    begin
      $display(">>> PASS");
    end
    else
    begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
logic/lb_pkg.sv
logic/i2c_pkg.sv
logic/lb_arbiter.sv
logic/i2c_tick_gen.sv
logic/i2c_master.sv
logic/i2c_ctrl_top.sv
tests/i2c_ctrl_assertions.sv
tests/tb_i2c_ctrl.sv

// File: Bender.yml
package:
  name: i2c_ctrl

sources:
  - files:
      - logic/lb_pkg.sv
      - logic/i2c_pkg.sv
      - logic/lb_arbiter.sv
      - logic/i2c_tick_gen.sv
      - logic/i2c_master.sv
      - logic/i2c_ctrl_top.sv
  - target: test
    files:
      - tests/i2c_ctrl_assertions.sv
      - tests/tb_i2c_ctrl.sv
